// File: design/timer_cfg.svh
// Width and address settings for the timer unit, included by the packages and RTL that need them
`ifndef TIMER_CFG_SVH
`define TIMER_CFG_SVH

// Counter and reload width, any value from 4 to 32
`define TIMER_WIDTH 8

// Prescale ratio field, tick every prescale+1 clocks
`define TIMER_PRESCALE_WIDTH 4

// Saturating expiration counter
`define TIMER_EVT_CNT_WIDTH 8

// Register port
`define TIMER_ADDR_WIDTH 2
`define TIMER_ADDR_CTRL 2'd0 // enable, irq_en, clear_status, prescale
`define TIMER_ADDR_RELOAD 2'd1 // reload value in the low bits

// Bus word seen by the register port
`define TIMER_DATA_WIDTH 32

// Padding above the control fields
`define TIMER_CTRL_PAD_WIDTH (`TIMER_DATA_WIDTH - 3 - `TIMER_PRESCALE_WIDTH)

`endif

// File: design/timer_reg_pkg.sv
// Register-side types of the timer unit, imported by the decode stage and the top level
`default_nettype none

`include "timer_cfg.svh"

package timer_reg_pkg;

    // Control register as laid out on the bus, enable in bit 0
    typedef struct packed {
        logic [`TIMER_CTRL_PAD_WIDTH-1:0]  pad;          // Ignored on write
        logic [`TIMER_PRESCALE_WIDTH-1:0]  prescale;     // Divide ratio minus one
        logic                              clear_status; // Self-clearing request
        logic                              irq_en;       // Interrupt gate
        logic                              enable;       // Timer run
    } timer_ctrl_view_s;

    // One bus word, decoded as control or as reload by address
    // Reload view keeps the whole word so a 32-bit counter still fits
    typedef union packed {
        timer_ctrl_view_s                  ctrl_view;
        logic [`TIMER_DATA_WIDTH-1:0]      reload_view;  // Reload in low TIMER_WIDTH bits
    } timer_wr_word_u;

    // Held configuration produced by the decode stage
    typedef struct packed {
        logic                              enable;
        logic                              irq_en;
        logic [`TIMER_PRESCALE_WIDTH-1:0]  prescale;
        logic [`TIMER_WIDTH-1:0]           reload;
    } timer_cfg_s;

endpackage

`default_nettype wire

// File: design/timer_evt_pkg.sv
// Event-side types of the timer unit, passed between prescaler, counter and capture stages
`default_nettype none

`include "timer_cfg.svh"

package timer_evt_pkg;

    // Prescaler output, all fields registered together with the tick
    typedef struct packed {
        logic                     tick;        // One-cycle count pulse
        logic                     debug_mode;  // Freeze request, aligned to tick
        logic                     irq_en;      // Carried toward the capture stage
        logic [`TIMER_WIDTH-1:0]  reload;      // Value loaded on wrap
    } timer_tick_s;

    // Counter output to the capture stage
    typedef struct packed {
        logic [`TIMER_WIDTH-1:0]  count;       // Current count
        logic                     expired;     // Single pulse on wrap reload
        logic                     irq_en;      // Passed along unchanged
    } timer_state_s;

endpackage

`default_nettype wire

// File: design/timer_cmd_decode.sv
// Decode stage of the timer unit; turns register writes into held config and a status-clear pulse
`timescale 1ns/100ps
`default_nettype none

`include "timer_cfg.svh"

module timer_cmd_decode
    import timer_reg_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wr_en,    // One-cycle write strobe
    input  logic [`TIMER_ADDR_WIDTH-1:0]  wr_addr,
    input  timer_wr_word_u                wr_data,
    output timer_cfg_s                    cfg,      // Held configuration
    output logic                          clear     // Status clear, one cycle
);

    timer_cfg_s               cfg_q;
    logic                     clear_q;
    logic                     ctrl_wr;    // Control register hit
    logic                     reload_wr;  // Reload register hit
    timer_ctrl_view_s         ctrl_word;
    logic [`TIMER_WIDTH-1:0]  reload_word;

    // Address decode, other addresses fall through and are dropped
    assign ctrl_wr   = wr_en && (wr_addr == `TIMER_ADDR_CTRL);
    assign reload_wr = wr_en && (wr_addr == `TIMER_ADDR_RELOAD);

    // Same bus word, two views
    assign ctrl_word   = wr_data.ctrl_view;
    assign reload_word = wr_data.reload_view[`TIMER_WIDTH-1:0];

    // Configuration registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_q <= '0; // Timer disabled out of reset
        end else begin
            if (ctrl_wr) begin
                cfg_q.enable   <= ctrl_word.enable;
                cfg_q.irq_en   <= ctrl_word.irq_en;
                cfg_q.prescale <= ctrl_word.prescale;
            end
            if (reload_wr) begin
                cfg_q.reload <= reload_word; // Used at next wrap
            end
        end
    end

    // Clear request lives for exactly one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clear_q <= 1'b0;
        end else begin
            clear_q <= ctrl_wr && ctrl_word.clear_status;
        end
    end

    assign cfg   = cfg_q;
    assign clear = clear_q;

endmodule

`default_nettype wire

// File: design/timer_prescaler.sv
// Prescale stage of the timer unit; divides the clock into count ticks and aligns side info to them
`timescale 1ns/100ps
`default_nettype none

`include "timer_cfg.svh"

module timer_prescaler
    import timer_reg_pkg::*;
    import timer_evt_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  timer_cfg_s   cfg,
    input  logic         debug_mode,  // Level from debug controller
    output timer_tick_s  tick_info
);

    logic [`TIMER_PRESCALE_WIDTH-1:0]  div_cnt;   // Clocks since last tick
    logic                              div_done;  // Ratio reached this cycle
    logic                              tick_q;
    logic                              debug_q;
    logic                              irq_en_q;
    logic [`TIMER_WIDTH-1:0]           reload_q;

    assign div_done = (div_cnt == cfg.prescale);

    // Divider and control copies
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt  <= '0;
            tick_q   <= 1'b0;
            debug_q  <= 1'b0;
            irq_en_q <= 1'b0;
            reload_q <= '0;
        end else begin
            debug_q  <= debug_mode;
            irq_en_q <= cfg.irq_en;
            reload_q <= cfg.reload; // Reload payload follows the same stage
            if (!cfg.enable) begin
                div_cnt <= '0; // Restart from zero when stopped
                tick_q  <= 1'b0;
            end else if (div_done) begin
                div_cnt <= '0;
                tick_q  <= 1'b1; // One tick per prescale+1 clocks
            end else begin
                div_cnt <= div_cnt + 1'b1;
                tick_q  <= 1'b0;
            end
        end
    end

    assign tick_info.tick       = tick_q;
    assign tick_info.debug_mode = debug_q;
    assign tick_info.irq_en     = irq_en_q;
    assign tick_info.reload     = reload_q;

endmodule

`default_nettype wire

// File: design/debug_timer.sv
// Count stage of the timer unit; up-counter with wrap reload, debug freeze and pending reload
`timescale 1ns/100ps
`default_nettype none

`include "timer_cfg.svh"

module debug_timer
    import timer_evt_pkg::*;
#(
    parameter int WIDTH = `TIMER_WIDTH  // Must match the struct count width
) (
    input  logic          clk,
    input  logic          rst_n,
    input  timer_tick_s   tick_info,
    output timer_state_s  state
);

    // Counter actions
    localparam logic [1:0] ACT_HOLD = 2'b00;
    localparam logic [1:0] ACT_LOAD = 2'b01;
    localparam logic [1:0] ACT_INC  = 2'b10;
    localparam logic [1:0] ACT_PEND = 2'b11;

    logic [WIDTH-1:0]  count;
    logic [WIDTH-1:0]  count_d;         // Previous count, drives expired
    logic              reload_pending;  // Wrap owed from a debug stop
    logic              count_max;
    logic              wrap_due;        // At max or reload owed
    logic [2:0]        ctrl_sel;
    logic [1:0]        action;

    assign count_max = (count == {WIDTH{1'b1}});
    assign wrap_due  = count_max | reload_pending;
    assign ctrl_sel  = {tick_info.tick, tick_info.debug_mode, wrap_due};

    // Pick one action per cycle from tick, debug and wrap state
    always_comb begin
        case (ctrl_sel)
            3'b100:  action = ACT_INC;   // Normal count
            3'b101:  action = ACT_LOAD;  // Wrap, or owed wrap after debug
            3'b011:  action = ACT_PEND;  // Stopped at max in debug
            default: action = ACT_HOLD;  // Idle or frozen
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count          <= '0;
            count_d        <= '0;
            reload_pending <= 1'b0;
        end else begin
            count_d <= count;
            case (action)
                ACT_LOAD: begin
                    count          <= tick_info.reload;
                    reload_pending <= 1'b0; // Debt paid
                end
                ACT_INC: begin
                    count <= count + 1'b1;
                end
                ACT_PEND: begin
                    reload_pending <= 1'b1;
                end
                default: begin
                    count <= count; // Frozen
                end
            endcase
        end
    end

    // Expired from the delayed copy, so one pulse per wrap
    assign state.count   = count;
    assign state.expired = (count_d == {WIDTH{1'b1}}) && tick_info.tick
                           && !tick_info.debug_mode;
    assign state.irq_en  = tick_info.irq_en;

endmodule

`default_nettype wire

// File: design/timer_event_capture.sv
// Capture stage of the timer unit; counts expirations and holds the sticky status and interrupt
`timescale 1ns/100ps
`default_nettype none

`include "timer_cfg.svh"

module timer_event_capture
    import timer_evt_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst_n,
    input  timer_state_s                     state,
    input  logic                             clear,       // Wins over expired
    output logic [`TIMER_WIDTH-1:0]          count,
    output logic [`TIMER_EVT_CNT_WIDTH-1:0]  expire_cnt,
    output logic                             status,      // Sticky expiration flag
    output logic                             irq          // Level interrupt
);

    localparam logic [`TIMER_EVT_CNT_WIDTH-1:0] EVT_MAX = {`TIMER_EVT_CNT_WIDTH{1'b1}};

    logic [`TIMER_WIDTH-1:0]          count_q;
    logic [`TIMER_EVT_CNT_WIDTH-1:0]  evt_cnt_q;
    logic                             status_q;
    logic                             irq_en_q;
    logic                             evt_sat;    // Counter at ceiling

    assign evt_sat = (evt_cnt_q == EVT_MAX);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q   <= '0;
            evt_cnt_q <= '0;
            status_q  <= 1'b0;
            irq_en_q  <= 1'b0;
        end else begin
            count_q  <= state.count;  // One cycle behind the counter
            irq_en_q <= state.irq_en;
            if (clear) begin
                evt_cnt_q <= '0;
                status_q  <= 1'b0;
            end else if (state.expired) begin
                status_q <= 1'b1;
                if (!evt_sat) begin
                    evt_cnt_q <= evt_cnt_q + 1'b1; // Saturates at all ones
                end
            end
        end
    end

    assign count      = count_q;
    assign expire_cnt = evt_cnt_q;
    assign status     = status_q;
    assign irq        = status_q & irq_en_q; // Both registered

endmodule

`default_nettype wire

// File: design/timer_unit_top.sv
// Top level of the timer unit; chains decode, prescale, count and capture stages
`timescale 1ns/100ps
`default_nettype none

`include "timer_cfg.svh"

module timer_unit_top
    import timer_reg_pkg::*;
    import timer_evt_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             wr_en,
    input  logic [`TIMER_ADDR_WIDTH-1:0]     wr_addr,
    input  logic [`TIMER_DATA_WIDTH-1:0]     wr_data,
    input  logic                             debug_mode,
    output logic [`TIMER_WIDTH-1:0]          count,
    output logic [`TIMER_EVT_CNT_WIDTH-1:0]  expire_cnt,
    output logic                             status,
    output logic                             irq
);

    timer_cfg_s    cfg;        // Decode to prescale
    logic          clear;      // Decode to capture
    timer_tick_s   tick_info;  // Prescale to count
    timer_state_s  state;      // Count to capture

    // Stage 1
    timer_cmd_decode u_decode (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),  // Raw bus word seen through the union
        .cfg     (cfg),
        .clear   (clear)
    );

    // Stage 2
    timer_prescaler u_prescaler (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .debug_mode (debug_mode),
        .tick_info  (tick_info)
    );

    // Stage 3
    debug_timer #(
        .WIDTH (`TIMER_WIDTH)
    ) u_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .tick_info (tick_info),
        .state     (state)
    );

    // Stage 4
    timer_event_capture u_capture (
        .clk        (clk),
        .rst_n      (rst_n),
        .state      (state),
        .clear      (clear),
        .count      (count),
        .expire_cnt (expire_cnt),
        .status     (status),
        .irq        (irq)
    );

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
// Clock and reset source for the timer unit testbench, instantiated once by the testbench top
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS  = 100,  // Full clock period
    parameter int RST_CYCLES = 3     // Clocks with reset held low
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release lands on a falling edge, away from the flops' sampling edge
    initial begin
        rst_n = 1'b0;
        #(PERIOD_NS * RST_CYCLES);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: tests/tb_timer_unit.sv
// Table-driven testbench for the timer unit; compiled from filelist.f with this module as top
`timescale 1ns/100ps
`default_nettype none

`include "timer_cfg.svh"

module tb_timer_unit;

    localparam int MAX_ROWS    = 16;
    localparam int RST_TIMEOUT = 20;  // Clocks allowed for reset release
    localparam int PW          = `TIMER_PRESCALE_WIDTH;
    localparam logic [`TIMER_WIDTH-1:0]         CNT_MAX = {`TIMER_WIDTH{1'b1}};
    localparam logic [`TIMER_EVT_CNT_WIDTH-1:0] EVT_MAX = {`TIMER_EVT_CNT_WIDTH{1'b1}};

    // One stimulus row with its expected results
    typedef struct packed {
        logic                             do_wr;      // Write on the first cycle
        logic [`TIMER_ADDR_WIDTH-1:0]     addr;
        logic [`TIMER_DATA_WIDTH-1:0]     data;
        logic                             debug;      // Level held for the whole row
        logic                             wait_evt;   // Stop early once exp_cnt is seen
        logic [15:0]                      cycles;     // Run length, or timeout when waiting
        logic                             use_model;  // Count of expirations from the model
        logic [`TIMER_EVT_CNT_WIDTH-1:0]  exp_cnt;
        logic                             exp_status;
        logic                             exp_irq;
    } row_s;

    logic                             clk;
    logic                             rst_n;
    logic                             wr_en;
    logic [`TIMER_ADDR_WIDTH-1:0]     wr_addr;
    logic [`TIMER_DATA_WIDTH-1:0]     wr_data;
    logic                             debug_mode;
    logic [`TIMER_WIDTH-1:0]          count;
    logic [`TIMER_EVT_CNT_WIDTH-1:0]  expire_cnt;
    logic                             status;
    logic                             irq;

    row_s  rows [0:MAX_ROWS-1];
    int    n_rows;

    // Reference model state with one variable per pipeline register
    logic                             ref_en, ref_irq_en, ref_clear;
    logic [PW-1:0]                    ref_prescale, ref_div;
    logic [`TIMER_WIDTH-1:0]          ref_reload, ref_reload_r;
    logic                             ref_tick, ref_dbg, ref_irqen_r;
    logic [`TIMER_WIDTH-1:0]          ref_count, ref_count_d, ref_out_count;
    logic                             ref_pending, ref_status, ref_irqen_c;
    logic [`TIMER_EVT_CNT_WIDTH-1:0]  ref_evt;

    tb_clock_gen #(.PERIOD_NS(100), .RST_CYCLES(3)) u_clk (.clk(clk), .rst_n(rst_n));

    timer_unit_top u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .debug_mode (debug_mode),
        .count      (count),
        .expire_cnt (expire_cnt),
        .status     (status),
        .irq        (irq)
    );

    task automatic fail_stop();
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped on the first failure");
    endtask

    task automatic check_eq(input string what, input int got, input int exp);
        assert (got == exp) else begin
            $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            fail_stop();
        end
    endtask

    // Control word with enable in bit 0, irq_en in bit 1, clear in bit 2 and prescale above
    function automatic logic [`TIMER_DATA_WIDTH-1:0] ctrl_word(input logic en, input logic irq_on,
                                                               input logic clr,
                                                               input logic [PW-1:0] ratio);
        ctrl_word            = '0;
        ctrl_word[0]         = en;
        ctrl_word[1]         = irq_on;
        ctrl_word[2]         = clr;
        ctrl_word[3 +: PW]   = ratio;
    endfunction

    // Advance the model by one clock with later stages first so each reads old state
    task automatic model_step(input logic we, input logic [`TIMER_ADDR_WIDTH-1:0] a,
                              input logic [`TIMER_DATA_WIDTH-1:0] d, input logic dbg);
        logic expired;
        expired = (ref_count_d == CNT_MAX) && ref_tick && !ref_dbg; // Wrap seen one cycle late
        ref_out_count = ref_count;
        ref_irqen_c   = ref_irqen_r;
        if (ref_clear) begin
            ref_evt    = '0; // Clear beats an expiration
            ref_status = 1'b0;
        end else if (expired) begin
            ref_status = 1'b1;
            if (ref_evt != EVT_MAX) ref_evt = ref_evt + 1'b1;
        end
        ref_count_d = ref_count;
        if (ref_tick && !ref_dbg) begin
            if (ref_count == CNT_MAX || ref_pending) begin
                ref_count   = ref_reload_r; // Wrap, or reload owed from debug
                ref_pending = 1'b0;
            end else begin
                ref_count = ref_count + 1'b1;
            end
        end else if (ref_dbg && !ref_tick && ref_count == CNT_MAX) begin
            ref_pending = 1'b1;
        end
        ref_dbg      = dbg;
        ref_irqen_r  = ref_irq_en;
        ref_reload_r = ref_reload;
        if (!ref_en) begin
            ref_div  = '0;
            ref_tick = 1'b0;
        end else begin
            ref_tick = (ref_div == ref_prescale); // One tick per prescale+1 clocks
            ref_div  = ref_tick ? '0 : ref_div + 1'b1;
        end
        ref_clear = we && (a == `TIMER_ADDR_CTRL) && d[2];
        if (we && a == `TIMER_ADDR_CTRL) begin
            ref_en       = d[0];
            ref_irq_en   = d[1];
            ref_prescale = d[3 +: PW];
        end
        if (we && a == `TIMER_ADDR_RELOAD) ref_reload = d[`TIMER_WIDTH-1:0];
    endtask

    task automatic check_outputs();
        check_eq("count", count, ref_out_count);
        check_eq("expire_cnt", expire_cnt, ref_evt);
        check_eq("status", status, ref_status);
        check_eq("irq", irq, ref_status & ref_irqen_c);
    endtask

    // Drive 1 ns after an edge, clock once, then compare after the next edge settles
    task automatic run_cycle(input logic we, input logic [`TIMER_ADDR_WIDTH-1:0] a,
                             input logic [`TIMER_DATA_WIDTH-1:0] d, input logic dbg);
        wr_en      = we;
        wr_addr    = a;
        wr_data    = d;
        debug_mode = dbg;
        @(posedge clk);
        model_step(we, a, d, dbg);
        #1;
        check_outputs();
    endtask

    task automatic add_row(input logic do_wr, input logic [`TIMER_ADDR_WIDTH-1:0] addr,
                           input logic [`TIMER_DATA_WIDTH-1:0] data, input logic debug,
                           input logic wait_evt, input int cycles, input int exp_cnt,
                           input logic exp_status, input logic exp_irq);
        row_s r;
        r.do_wr      = do_wr;
        r.addr       = addr;
        r.data       = data;
        r.debug      = debug;
        r.wait_evt   = wait_evt;
        r.cycles     = cycles[15:0];
        r.use_model  = (exp_cnt < 0); // Negative means ask the model
        r.exp_cnt    = exp_cnt[`TIMER_EVT_CNT_WIDTH-1:0];
        r.exp_status = exp_status;
        r.exp_irq    = exp_irq;
        rows[n_rows] = r;
        n_rows       = n_rows + 1;
    endtask

    initial begin : main
        int                       seed;
        int                       i;
        int                       n;
        logic                     done;
        logic [`TIMER_WIDTH-1:0]  rand_reload;
        row_s                     r;
        wr_en      = 1'b0;
        wr_addr    = '0;
        wr_data    = '0;
        debug_mode = 1'b0;
        {ref_en, ref_irq_en, ref_clear, ref_prescale, ref_div, ref_reload} = '0;
        {ref_reload_r, ref_tick, ref_dbg, ref_irqen_r, ref_count, ref_count_d} = '0;
        {ref_out_count, ref_pending, ref_status, ref_irqen_c, ref_evt} = '0;
        n_rows      = 0;
        seed        = 3;
        rand_reload = $random(seed);
        $display("Random reload %0h, wrap period %0d ticks", rand_reload,
                 (1 << `TIMER_WIDTH) - rand_reload);

        // wr, addr, data, debug, wait, cycles, expire_cnt, status, irq
        add_row(0, 0, 0, 0, 0, 20, 0, 0, 0);                                // Idle after reset
        add_row(1, `TIMER_ADDR_RELOAD, 32'hF0, 0, 0, 1, 0, 0, 0);
        add_row(1, `TIMER_ADDR_CTRL, ctrl_word(1, 0, 0, 0), 0, 1, 400, 1, 1, 0);
        add_row(0, 0, 0, 0, 1, 40, 2, 1, 0);                                // 16 ticks later
        add_row(1, `TIMER_ADDR_CTRL, ctrl_word(1, 1, 0, 0), 0, 0, 3, 2, 1, 1);
        add_row(1, `TIMER_ADDR_CTRL, ctrl_word(1, 1, 0, 3), 0, 0, 32, 2, 1, 1); // Slow ticks
        add_row(0, 0, 0, 0, 1, 100, 3, 1, 1);
        add_row(0, 0, 0, 0, 0, 60, 3, 1, 1);                                // Stops at max
        add_row(0, 0, 0, 1, 0, 50, 3, 1, 1);                                // Frozen and owes reload
        add_row(0, 0, 0, 0, 0, 8, 4, 1, 1);                                 // Owed reload paid
        add_row(1, `TIMER_ADDR_CTRL, ctrl_word(1, 1, 1, 3), 0, 0, 3, 0, 0, 0);
        add_row(1, `TIMER_ADDR_RELOAD, rand_reload, 0, 0, 1, 0, 0, 0);
        add_row(1, `TIMER_ADDR_CTRL, ctrl_word(1, 1, 0, 0), 0, 0, 600, -1, 1, 1);
        add_row(1, `TIMER_ADDR_CTRL, ctrl_word(1, 1, 1, 0), 0, 1, 400, 1, 1, 1);

        n = 0;
        while (rst_n !== 1'b1 && n < RST_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("Reset was never released by the clock generator");
            fail_stop();
        end
        #1;

        for (i = 0; i < n_rows; i++) begin
            r    = rows[i];
            n    = 0;
            done = 1'b0;
            while (!done) begin
                run_cycle(r.do_wr && (n == 0), r.addr, r.data, r.debug);
                n++;
                done = (n >= r.cycles) || (r.wait_evt && expire_cnt == r.exp_cnt);
            end
            if (r.wait_evt && expire_cnt != r.exp_cnt) begin
                $display("No expiration arrived within %0d cycles in row %0d", r.cycles, i);
                fail_stop();
            end
            if (!r.use_model) begin
                check_eq($sformatf("row %0d expire_cnt", i), expire_cnt, r.exp_cnt);
            end
            check_eq($sformatf("row %0d status", i), status, r.exp_status);
            check_eq($sformatf("row %0d irq", i), irq, r.exp_irq);
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+design
design/timer_reg_pkg.sv
design/timer_evt_pkg.sv
design/timer_cmd_decode.sv
design/timer_prescaler.sv
design/debug_timer.sv
design/timer_event_capture.sv
design/timer_unit_top.sv
tests/tb_clock_gen.sv
tests/tb_timer_unit.sv
